//--- csr_unit.f
+incdir+design
design/csr_pkg.sv
design/pipe_pkg.sv
design/csr_lane_check.sv
design/csr_pipe_reg.sv
design/excp_arbiter.sv
design/csr_regfile.sv
design/csr_unit.sv
bench/csr_unit_checker.sv
bench/csr_unit_tb.sv

//--- Makefile
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test: pass" || (echo "test: fail"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_unit_tb
    import csr_pkg::*;
    import pipe_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 400;           // tests run for about 65 cycles
    localparam logic [`XLEN-1:0] EENTRY_VAL = 32'h1c00_8000;

    logic                       clk;
    logic                       rstn;
    logic                       stall;
    logic                       br_fix;
    logic                       irq;
    ex_lane_t [`NUM_LANES-1:0]  ex_lane;
    csr_addr_e                  csr_raddr;
    logic [`XLEN-1:0]           csr_rdata;
    logic [1:0]                 plv;
    logic                       redirect_valid;
    logic [`XLEN-1:0]           redirect_pc;

    integer seed;
    int     n_checks;
    int     n_errors;
    int     cycle_count;

    logic [`XLEN-1:0] save0_exp;   // SAVE0 as the tests left it

    csr_unit u_csr_unit (
        .clk            (clk),
        .rstn           (rstn),
        .stall          (stall),
        .br_fix         (br_fix),
        .irq            (irq),
        .ex_lane        (ex_lane),
        .csr_raddr      (csr_raddr),
        .csr_rdata      (csr_rdata),
        .plv            (plv),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_ecode(input string name, input ecode_e exp, input ecode_e act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_redirect(input string name, input logic exp_valid,
                                  input logic [`XLEN-1:0] exp_pc);
        n_checks++;
        if (redirect_valid !== exp_valid || (exp_valid && redirect_pc !== exp_pc)) begin
            n_errors++;
            $display("mismatch %s expected %b/%h actual %b/%h", name, exp_valid, exp_pc,
                     redirect_valid, redirect_pc);
        end
    endtask

    // ESTAT Ecode sits in bits 21:16, and 0 there is the interrupt
    function automatic ecode_e estat_code(input logic [`XLEN-1:0] estat);
        if (estat[21:16] == 6'd0) begin
            return ECODE_INT;
        end
        return ecode_e'({1'b0, estat[21:16]});
    endfunction

    task automatic check_csr(input string name, input csr_addr_e addr,
                             input logic [`XLEN-1:0] exp);
        csr_raddr = addr;
        #1;
        check_word(name, exp, csr_rdata);
        step();
    endtask

    task automatic check_estat(input string name, input ecode_e exp);
        csr_raddr = CSR_ESTAT;
        #1;
        check_ecode(name, exp, estat_code(csr_rdata));
        step();
    endtask

    function automatic ex_lane_t new_lane(input lane_op_e op, input logic [`XLEN-1:0] pc);
        ex_lane_t l;
        l       = '0;
        l.valid = 1'b1;
        l.op    = op;
        l.pc    = pc;
        l.size  = 2'd2;
        return l;
    endfunction

    // Lanes are taken at the next edge, then EX goes idle
    task automatic issue(input ex_lane_t a, input ex_lane_t b);
        ex_lane[LANE_A] = a;
        ex_lane[LANE_B] = b;
        step();
        ex_lane = '0;
    endtask

    task automatic csr_write(input csr_addr_e addr, input logic [`XLEN-1:0] mask,
                             input logic [`XLEN-1:0] wdata);
        ex_lane_t b;
        b            = new_lane(OP_CSRWR, 32'h1c00_0010);
        b.csr.addr   = addr;
        b.csr.mask   = mask;
        b.csr.wdata  = wdata;
        issue('0, b);
        step();
        step();
    endtask

    task automatic masked_write_test();
        logic [`XLEN-1:0] old_val;
        logic [`XLEN-1:0] new_val;
        logic [`XLEN-1:0] mask;
        ex_lane_t b;
        old_val = $random(seed);
        new_val = $random(seed);
        mask    = $random(seed);
        if (mask == '0 || mask == '1) begin
            mask = 32'h00ff_ff00;
        end
        // Each bit comes from wdata where the mask is set
        for (int i = 0; i < `XLEN; i++) begin
            save0_exp[i] = mask[i] ? new_val[i] : old_val[i];
        end
        csr_write(CSR_SAVE0, '1, old_val);
        b           = new_lane(OP_CSRWR, 32'h1c00_0020);
        b.csr.addr  = CSR_SAVE0;
        b.csr.mask  = mask;
        b.csr.wdata = new_val;
        issue('0, b);
        step();
        csr_raddr = CSR_SAVE0;
        #1;
        check_word("masked_write before commit", old_val, csr_rdata);
        step();
        check_word("masked_write save0", save0_exp, csr_rdata);
    endtask

    task automatic ale_test();
        logic [`XLEN-1:0] addr;
        ex_lane_t a;
        ex_lane_t b;
        csr_write(CSR_EENTRY, '1, EENTRY_VAL);
        addr   = ($random(seed) & 32'hffff_fffc) | 32'h2;
        a      = new_lane(OP_ALU, 32'h1c00_0100);
        b      = new_lane(OP_STORE, 32'h1c00_0104);
        b.addr = addr;
        issue(a, b);
        step();
        check_redirect("ale redirect", 1'b1, EENTRY_VAL);
        step();
        check_estat("ale estat", ECODE_ALE);
        check_csr("ale badv", CSR_BADV, addr);
        check_csr("ale era", CSR_ERA, 32'h1c00_0104);
        a           = new_lane(OP_ALU, 32'h1c00_0200);
        a.fetch_err = 1'b1;                           // older lane wins
        issue(a, b);
        step();
        check_redirect("adef redirect", 1'b1, EENTRY_VAL);
        step();
        check_estat("adef estat", ECODE_ADEF);
        check_csr("adef badv", CSR_BADV, 32'h1c00_0200);
        check_csr("adef era", CSR_ERA, 32'h1c00_0200);
    endtask

    task automatic ipe_test();
        ex_lane_t b;
        csr_write(CSR_PRMD, 32'h7, 32'h3);
        issue('0, new_lane(OP_ERTN, 32'h1c00_0300));
        step();
        check_redirect("ipe ertn redirect", 1'b1, 32'h1c00_0200);
        step();
        check_word("ipe plv after ertn", 32'd3, {30'b0, plv});
        b           = new_lane(OP_CSRWR, 32'h1c00_0308);
        b.csr.addr  = CSR_SAVE0;
        b.csr.mask  = '1;
        b.csr.wdata = ~save0_exp;
        issue('0, b);
        step();
        check_redirect("ipe redirect", 1'b1, EENTRY_VAL);
        step();
        check_estat("ipe estat", ECODE_IPE);
        check_csr("ipe save0 kept", CSR_SAVE0, save0_exp);
        check_csr("ipe era", CSR_ERA, 32'h1c00_0308);
        check_csr("ipe prmd", CSR_PRMD, 32'h3);
    endtask

    task automatic int_test();
        csr_write(CSR_CRMD, 32'h7, 32'h4);
        check_csr("int crmd before", CSR_CRMD, 32'h4);
        irq = 1'b1;
        issue(new_lane(OP_ALU, 32'h1c00_0400), new_lane(OP_ALU, 32'h1c00_0404));
        step();
        irq = 1'b0;
        check_redirect("int redirect", 1'b1, EENTRY_VAL);
        step();
        check_estat("int estat", ECODE_INT);
        check_csr("int era", CSR_ERA, 32'h1c00_0400);
        check_csr("int prmd", CSR_PRMD, 32'h4);
        check_csr("int crmd", CSR_CRMD, 32'h0);
    endtask

    task automatic kill_stall_test();
        br_fix = 1'b1;
        issue(new_lane(OP_SYSCALL, 32'h1c00_0500), '0);
        br_fix = 1'b0;
        step();
        check_redirect("br_fix redirect", 1'b0, '0);
        step();
        check_estat("br_fix estat", ECODE_INT);
        check_csr("br_fix era", CSR_ERA, 32'h1c00_0400);
        issue(new_lane(OP_ALU, 32'h1c00_0600), new_lane(OP_BREAK, 32'h1c00_0604));
        stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            check_redirect("stall redirect", 1'b0, '0);
            check_csr("stall era", CSR_ERA, 32'h1c00_0400);
        end
        stall = 1'b0;
        step();
        check_redirect("stall release redirect", 1'b1, EENTRY_VAL);
        step();
        check_estat("stall estat", ECODE_BRK);
        check_csr("stall era after", CSR_ERA, 32'h1c00_0604);
        check_csr("stall badv kept", CSR_BADV, 32'h1c00_0200);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed      = 32'hc219_1749;
        n_checks  = 0;
        n_errors  = 0;
        save0_exp = '0;
        rstn      = 1'b0;
        stall     = 1'b0;
        br_fix    = 1'b0;
        irq       = 1'b0;
        ex_lane   = '0;
        csr_raddr = CSR_CRMD;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_redirect("reset redirect", 1'b0, '0);
        check_word("reset plv", 32'd0, {30'b0, plv});
        check_csr("reset crmd", CSR_CRMD, 32'h0);
        masked_write_test();
        ale_test();
        ipe_test();
        int_test();
        kill_stall_test();
        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/csr_unit_checker.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_checker
    import pipe_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input logic        stall,
    input mem_stage_t  mem,
    input wb_stage_t   wb
);

    flush_clears_mem: assert property (@(posedge clk) disable iff (!rstn)
        wb.flush |=> !mem.valid)
        else $error("MEM still valid one cycle after a WB flush");

    // Flush wins over stall
    stall_holds: assert property (@(posedge clk) disable iff (!rstn)
        stall && !wb.flush |=> $stable(mem) && $stable(wb))
        else $error("MEM or WB changed while stalled");

    reset_no_redirect: assert property (@(posedge clk)
        !rstn |=> !wb.flush && !wb.ertn)
        else $error("redirect source active during reset");

    reset_mem_empty: assert property (@(posedge clk)
        $rose(rstn) |-> !mem.valid)
        else $error("MEM valid right after reset release");

endmodule

bind csr_pipe_reg csr_unit_checker u_checker (
    .clk   (clk),
    .rstn  (rstn),
    .stall (stall),
    .mem   (mem),
    .wb    (wb)
);

`default_nettype wire

//--- design/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_unit
    import csr_pkg::*;
    import pipe_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       stall,
    input  logic                       br_fix,
    input  logic                       irq,
    input  ex_lane_t [`NUM_LANES-1:0]  ex_lane,
    input  csr_addr_e                  csr_raddr,
    output logic [`XLEN-1:0]           csr_rdata,
    output logic [1:0]                 plv,
    output logic                       redirect_valid,
    output logic [`XLEN-1:0]           redirect_pc
);

    crmd_t                        crmd;
    lane_excp_t [`NUM_LANES-1:0]  ex_excp;
    mem_stage_t                   mem;
    wb_stage_t                    wb;
    wb_stage_t                    wb_next;

    assign plv = crmd.plv;

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        csr_lane_check u_lane_check (
            .lane (ex_lane[i]),
            .plv  (crmd.plv),
            .excp (ex_excp[i])
        );
    end

    csr_pipe_reg u_pipe_reg (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .br_fix  (br_fix),
        .ex_excp (ex_excp),
        .ex_lane (ex_lane),
        .wb_next (wb_next),
        .mem     (mem),
        .wb      (wb)
    );

    excp_arbiter u_arbiter (
        .mem     (mem),
        .irq     (irq),
        .crmd    (crmd),
        .wb_next (wb_next)
    );

    csr_regfile u_regfile (
        .clk            (clk),
        .rstn           (rstn),
        .wb             (wb),
        .raddr          (csr_raddr),
        .rdata          (csr_rdata),
        .crmd           (crmd),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- design/csr_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_regfile
    import csr_pkg::*;
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  wb_stage_t         wb,
    input  csr_addr_e         raddr,
    output logic [`XLEN-1:0]  rdata,
    output crmd_t             crmd,
    output logic              redirect_valid,
    output logic [`XLEN-1:0]  redirect_pc
);

    crmd_t             prmd;        // PPLV and PIE
    logic [5:0]        estat_ecode;
    logic [`XLEN-1:0]  era;
    logic [`XLEN-1:0]  badv;
    logic [`XLEN-1:0]  eentry;
    logic [`XLEN-1:0]  save0;

    logic [`XLEN-1:0]  wr_old;
    logic [`XLEN-1:0]  wr_val;
    logic              wr_en;

    function automatic logic [`XLEN-1:0] csr_value(input csr_addr_e addr);
        logic [`XLEN-1:0] val;
        case (addr)
            CSR_CRMD:   val = {29'b0, crmd};
            CSR_PRMD:   val = {29'b0, prmd};
            CSR_ESTAT:  val = {10'b0, estat_ecode, 16'b0};
            CSR_ERA:    val = era;
            CSR_BADV:   val = badv;
            CSR_EENTRY: val = eentry;
            CSR_SAVE0:  val = save0;
            default:    val = '0;
        endcase
        return val;
    endfunction

    always_comb begin
        rdata  = csr_value(raddr);
        wr_old = csr_value(wb.csr.addr);
    end

    assign wr_val = (wr_old & ~wb.csr.mask) | (wb.csr.wdata & wb.csr.mask);
    assign wr_en  = |wb.csr.mask;

    assign redirect_valid = wb.flush || wb.ertn;
    assign redirect_pc    = wb.flush ? eentry : era;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd        <= '0;
            prmd        <= '0;
            estat_ecode <= '0;
            era         <= '0;
            badv        <= '0;
            eentry      <= '0;
            save0       <= '0;
        end else if (wb.flush) begin
            // Exception or interrupt entry
            prmd        <= crmd;
            crmd        <= '0;
            estat_ecode <= wb.ecode[5:0];
            era         <= wb.era;
            if (wb.badv_valid) begin
                badv <= wb.badv;
            end
        end else if (wb.ertn) begin
            crmd <= prmd;
        end else if (wr_en) begin
            case (wb.csr.addr)
                CSR_CRMD:   crmd   <= crmd_t'(wr_val[2:0]);
                CSR_PRMD:   prmd   <= crmd_t'(wr_val[2:0]);
                CSR_ERA:    era    <= wr_val;
                CSR_BADV:   badv   <= wr_val;
                CSR_EENTRY: eentry <= {wr_val[`XLEN-1:6], 6'b0}; // 64-byte aligned
                CSR_SAVE0:  save0  <= wr_val;
                default:    ;                                    // ESTAT Ecode is read only
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/excp_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module excp_arbiter
    import csr_pkg::*;
    import pipe_pkg::*;
(
    input  mem_stage_t  mem,
    input  logic        irq,
    input  crmd_t       crmd,
    output wb_stage_t   wb_next
);

    logic a_excp;
    logic b_excp;
    logic take_int;

    assign a_excp   = mem.lane[LANE_A].ecode != ECODE_NONE;
    assign b_excp   = mem.lane[LANE_B].ecode != ECODE_NONE;
    assign take_int = irq && crmd.ie && mem.valid && !a_excp && !b_excp;

    always_comb begin
        wb_next.csr        = mem.csr;
        wb_next.ertn       = mem.ertn;
        wb_next.ecode      = ECODE_NONE;
        wb_next.era        = mem.lane[LANE_A].pc;
        wb_next.badv       = mem.lane[LANE_A].badv;
        wb_next.badv_valid = 1'b0;
        wb_next.flush      = 1'b0;

        // Older lane first
        if (a_excp) begin
            wb_next.ecode      = mem.lane[LANE_A].ecode;
            wb_next.badv_valid = mem.lane[LANE_A].badv_valid;
            wb_next.flush      = 1'b1;
        end else if (b_excp) begin
            wb_next.ecode      = mem.lane[LANE_B].ecode;
            wb_next.era        = mem.lane[LANE_B].pc;
            wb_next.badv       = mem.lane[LANE_B].badv;
            wb_next.badv_valid = mem.lane[LANE_B].badv_valid;
            wb_next.flush      = 1'b1;
        end else if (take_int) begin
            wb_next.ecode = ECODE_INT; // returns to lane A
            wb_next.flush = 1'b1;
        end

        if (wb_next.flush) begin
            wb_next.csr.mask = '0; // IPE write must not land
            wb_next.ertn     = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/csr_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_pipe_reg
    import pipe_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         stall,
    input  logic                         br_fix,
    input  lane_excp_t [`NUM_LANES-1:0]  ex_excp,
    input  ex_lane_t [`NUM_LANES-1:0]    ex_lane,
    input  wb_stage_t                    wb_next,
    output mem_stage_t                   mem,
    output wb_stage_t                    wb
);

    mem_stage_t mem_in;
    logic       ex_has_excp;
    logic       b_csrwr;
    logic       b_ertn;

    assign ex_has_excp = (ex_excp[LANE_A].ecode != ECODE_NONE) ||
                         (ex_excp[LANE_B].ecode != ECODE_NONE);

    // CSRWR and ERTN only ever issue alone in lane B
    assign b_csrwr = ex_lane[LANE_B].valid && (ex_lane[LANE_B].op == OP_CSRWR);
    assign b_ertn  = ex_lane[LANE_B].valid && (ex_lane[LANE_B].op == OP_ERTN);

    always_comb begin
        mem_in.lane  = ex_excp;
        mem_in.csr   = ex_lane[LANE_B].csr;
        if (!b_csrwr) begin
            mem_in.csr.mask = '0;
        end
        mem_in.ertn  = b_ertn && !ex_has_excp; // faulting ERTN never returns
        mem_in.valid = ex_lane[LANE_A].valid || ex_lane[LANE_B].valid;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem <= '0;
            wb  <= '0;
        end else if (wb.flush) begin
            // Flush wins over stall and only a fresh interrupt survives
            mem <= '0;
            if (wb_next.ecode == ECODE_INT) begin
                wb <= wb_next;
            end else begin
                wb <= '0;
            end
        end else if (!stall) begin
            if (br_fix) begin
                mem <= '0; // wrong-path entry
            end else begin
                mem <= mem_in;
            end
            wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

//--- design/csr_lane_check.sv
`timescale 1ns/10ps
`default_nettype none

module csr_lane_check
    import pipe_pkg::*;
(
    input  ex_lane_t    lane,
    input  logic [1:0]  plv,
    output lane_excp_t  excp
);

    logic is_mem;
    logic misaligned;
    logic is_priv;

    assign is_mem  = (lane.op == OP_LOAD) || (lane.op == OP_STORE);
    assign is_priv = (lane.op == OP_CSRWR) || (lane.op == OP_ERTN);

    always_comb begin
        case (lane.size)
            2'd1:    misaligned = lane.addr[0];
            2'd2:    misaligned = |lane.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Fetch error first as the oldest fault of the instruction
    always_comb begin
        excp.ecode      = ECODE_NONE;
        excp.badv       = lane.addr;
        excp.badv_valid = 1'b0;
        excp.pc         = lane.pc;
        if (lane.valid) begin
            if (lane.fetch_err) begin
                excp.ecode      = ECODE_ADEF;
                excp.badv       = lane.pc;
                excp.badv_valid = 1'b1;
            end else if (is_mem && misaligned) begin
                excp.ecode      = ECODE_ALE;
                excp.badv_valid = 1'b1;
            end else if (lane.op == OP_SYSCALL) begin
                excp.ecode = ECODE_SYS;
            end else if (lane.op == OP_BREAK) begin
                excp.ecode = ECODE_BRK;
            end else if (is_priv && plv == 2'd3) begin
                excp.ecode = ECODE_IPE; // user level
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pipe_pkg.sv
`default_nettype none

`include "csr_macros.svh"

package pipe_pkg;

    import csr_pkg::*;

    localparam int LANE_A = 0; // older
    localparam int LANE_B = 1; // younger

    typedef enum logic [2:0] {
        OP_NOP,
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_CSRWR,
        OP_SYSCALL,
        OP_BREAK,
        OP_ERTN
    } lane_op_e;

    // Low six bits are the architectural Ecode.
    // INT is 0 in ESTAT, so bit 6 tags it apart from NONE
    typedef enum logic [`ECODE_W-1:0] {
        ECODE_NONE = 7'h00,
        ECODE_INT  = 7'h40,
        ECODE_ADEF = 7'h08,
        ECODE_ALE  = 7'h09,
        ECODE_SYS  = 7'h0b,
        ECODE_BRK  = 7'h0c,
        ECODE_IPE  = 7'h0e
    } ecode_e;

    typedef struct packed {
        logic              valid;
        lane_op_e          op;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  addr;
        logic [1:0]        size;      // 0 byte, 1 half, 2 word
        csr_wreq_t         csr;
        logic              fetch_err;
    } ex_lane_t;

    typedef struct packed {
        ecode_e            ecode;
        logic [`XLEN-1:0]  badv;
        logic              badv_valid;
        logic [`XLEN-1:0]  pc;
    } lane_excp_t;

    typedef struct packed {
        lane_excp_t [`NUM_LANES-1:0]  lane;
        csr_wreq_t                    csr;
        logic                         ertn;
        logic                         valid;
    } mem_stage_t;

    typedef struct packed {
        csr_wreq_t         csr;
        logic              ertn;
        ecode_e            ecode;
        logic [`XLEN-1:0]  era;
        logic [`XLEN-1:0]  badv;
        logic              badv_valid;
        logic              flush;     // exception or interrupt entry
    } wb_stage_t;

endpackage

`default_nettype wire

//--- design/csr_pkg.sv
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030
    } csr_addr_e;

    // Mask bit set means the wdata bit lands
    typedef struct packed {
        csr_addr_e         addr;
        logic [`XLEN-1:0]  mask;
        logic [`XLEN-1:0]  wdata;
    } csr_wreq_t;

    // Same layout as CRMD[2:0], reused for PRMD
    typedef struct packed {
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

endpackage

`default_nettype wire

//--- design/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Data and address width
`define XLEN 32

`define CSR_ADDR_W 14

// Ecode plus one tag bit
`define ECODE_W 7

`define NUM_LANES 2

`endif
